/* Makefile */
VERILATOR ?= verilator
TOP       := tb_alu_pipe
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))
PASS_MSG  := *** PASSED ***

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* alu_exec_stage.sv */
// Combinational execute stage
module alu_exec_stage
  import isa_pkg::*;
  import result_pkg::*;
(
  input  logic                  valid_i,
  input  logic                  ready_i,
  input  cmd_u                  cmd_i,
  output logic                  valid_o,
  output logic                  ready_o,
  output logic [res_width-1:0]  result_o,
  output logic [flag_width-1:0] flags_o
);

  // Zero-extended operands of the pair layout
  logic [res_width-1:0] operand_a;
  logic [res_width-1:0] operand_b;

  // Left shift of the wide value, kept to 24 bits
  logic [wide_width-1:0] shl_value;

  // Two copies of the wide value side by side for the rotate
  logic [2*wide_width-1:0] rol_pair;
  logic [wide_width-1:0]   rol_value;

  // Set when the opcode does not match any known command
  logic illegal;

  // The stage adds no storage, so both handshake directions pass through
  // and the spill registers on either side carry all the timing
  assign valid_o = valid_i;
  assign ready_o = ready_i;

  // Pair operands are 14 bits wide and are widened to the result width
  // before any arithmetic, so carries and borrows reach the upper bits
  assign operand_a = res_width'(cmd_i.pair.operand_a);
  assign operand_b = res_width'(cmd_i.pair.operand_b);

  // Bits pushed past position 23 are dropped
  assign shl_value = cmd_i.wide.value << cmd_i.wide.shamt;

  // Shifting the doubled value left lets the bits that leave the top of
  // the lower copy reappear at its bottom, the upper half is the rotate
  assign rol_pair  = {cmd_i.wide.value, cmd_i.wide.value} << cmd_i.wide.shamt;
  assign rol_value = rol_pair[2*wide_width-1:wide_width];

  // Opcode sits in the same place in both views, the pair view is used to
  // read it and the matching view is used to read the operands
  always_comb begin
    result_o = illegal_result;
    illegal  = 1'b0;
    case (cmd_i.pair.opcode)
      op_add: begin
        result_o = operand_a + operand_b;
      end
      op_sub: begin
        // Wraps modulo 2**32 when operand_b is the larger one
        result_o = operand_a - operand_b;
      end
      op_and: begin
        result_o = operand_a & operand_b;
      end
      op_xor: begin
        result_o = operand_a ^ operand_b;
      end
      op_shl: begin
        result_o = res_width'(shl_value);
      end
      op_rol: begin
        result_o = res_width'(rol_value);
      end
      default: begin
        // Unknown opcodes keep the fixed illegal result
        illegal = 1'b1;
      end
    endcase
  end

  // Status flags are formed from the final result, so an illegal command
  // also reports zero
  always_comb begin
    flags_o                   = '0;
    flags_o[flag_zero_idx]    = (result_o == '0);
    flags_o[flag_illegal_idx] = illegal;
  end

endmodule

/* alu_pipe_top.sv */
// Two-stage operand pipeline top
module alu_pipe_top
  import isa_pkg::*;
  import result_pkg::*;
#(
  // Bypass selection for the input and output spill registers
  parameter bit in_bypass  = 1'b0,
  parameter bit out_bypass = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  cmd_valid_i,
  input  logic [cmd_width-1:0]  cmd_data_i,
  output logic                  cmd_ready_o,
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [res_width-1:0]  res_data_o,
  output logic [flag_width-1:0] res_flags_o
);

  // Link from the input register into the execute stage
  logic                 exec_valid;
  logic                 exec_ready;
  logic [cmd_width-1:0] exec_cmd;

  // Link from the execute stage into the output register
  logic                  out_valid;
  logic                  out_ready;
  logic [res_width-1:0]  exec_result;
  logic [flag_width-1:0] exec_flags;

  // Result and flags travel through the output register as one word
  logic [res_width+flag_width-1:0] res_word;

  spill_register_flushable #(
    .data_width (cmd_width),
    .bypass     (in_bypass)
  ) i_in_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cmd_valid_i),
    .flush_i (flush_i),
    .ready_o (cmd_ready_o),
    .data_i  (cmd_data_i),
    .valid_o (exec_valid),
    .ready_i (exec_ready),
    .data_o  (exec_cmd)
  );

  alu_exec_stage i_exec (
    .valid_i  (exec_valid),
    .ready_i  (out_ready),
    .cmd_i    (exec_cmd),
    .valid_o  (out_valid),
    .ready_o  (exec_ready),
    .result_o (exec_result),
    .flags_o  (exec_flags)
  );

  // Same flush reaches both registers, so every slot empties on one edge
  spill_register_flushable #(
    .data_width (res_width + flag_width),
    .bypass     (out_bypass)
  ) i_out_spill (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (out_valid),
    .flush_i (flush_i),
    .ready_o (out_ready),
    .data_i  ({exec_result, exec_flags}),
    .valid_o (res_valid_o),
    .ready_i (res_ready_i),
    .data_o  (res_word)
  );

  // Split the packed output word back into result and flags
  assign res_data_o  = res_word[res_width+flag_width-1:flag_width];
  assign res_flags_o = res_word[flag_width-1:0];

  // The decoder only sees defined opcodes and operands while a command is valid
  exec_cmd_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) exec_valid |-> !$isunknown(exec_cmd)
  ) else $error("execute stage input holds unknown bits while valid");

  // A flush leaves nothing to present in the following cycle
  // With both registers bypassed there is no storage and the check does not apply
  flush_empties_output: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (flush_i && !(in_bypass && out_bypass)) |=> !res_valid_o
  ) else $error("res_valid_o still high in the cycle after a flush");

endmodule

/* isa_pkg.sv */
// Command word encoding
package isa_pkg;

  // Every command travels as one 32-bit word
  parameter int unsigned cmd_width = 32;

  // Field widths shared by both layouts of the command word
  parameter int unsigned opcode_width  = 4;
  parameter int unsigned pair_op_width = 14;
  parameter int unsigned wide_width    = 24;
  parameter int unsigned shamt_width   = 4;

  // Opcodes in the low half of the code space use the pair layout
  // and the ones starting at 4'h8 use the wide layout
  // Codes not listed here are illegal and are flagged by the execute stage
  typedef enum logic [opcode_width-1:0] {
    op_add = 4'h0,
    op_sub = 4'h1,
    op_and = 4'h2,
    op_xor = 4'h3,
    op_shl = 4'h8,
    op_rol = 4'h9
  } opcode_e;

  // One word with two readings, both keep the opcode in the top nibble
  // Pair view holds two small operands for the arithmetic and logic ops
  // Wide view holds a 24-bit value and a shift amount for shl and rol
  typedef union packed {
    struct packed {
      opcode_e                  opcode;
      logic [pair_op_width-1:0] operand_a;
      logic [pair_op_width-1:0] operand_b;
    } pair;
    struct packed {
      opcode_e                opcode;
      logic [wide_width-1:0]  value;
      logic [shamt_width-1:0] shamt;
    } wide;
  } cmd_u;

endpackage

/* result_pkg.sv */
// Result and status flag encoding
package result_pkg;

  // Width of the computed result word
  parameter int unsigned res_width = 32;

  // The flag port carries two status bits next to the result
  parameter int unsigned flag_width = 2;

  // Bit position of each status flag inside the flag port
  // Zero is set whenever the result word is all zeros
  parameter int unsigned flag_zero_idx = 0;
  // Illegal is set when the opcode is not one of the known codes
  parameter int unsigned flag_illegal_idx = 1;

  // An illegal command produces this result, so the zero flag is
  // raised along with the illegal flag
  parameter logic [res_width-1:0] illegal_result = '0;

endpackage

/* spill_register_flushable.sv */
// Flushable two-slot spill register
module spill_register_flushable #(
  // Width of the payload carried through the register
  parameter int unsigned data_width = 32,
  // When set the register collapses to plain wires
  parameter bit          bypass     = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  logic                  flush_i,
  output logic                  ready_o,
  input  logic [data_width-1:0] data_i,
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic [data_width-1:0] data_o
);

  if (bypass) begin : gen_bypass

    // Transparent variant with the handshake passed straight through
    // and the flush left without effect since nothing is stored
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;

  end else begin : gen_spill

    // Slot A takes new data from the input side
    logic [data_width-1:0] a_data_q;
    logic                  a_full_q;
    logic                  a_fill;
    logic                  a_drain;

    // Slot B catches the word from A when downstream stalls
    logic [data_width-1:0] b_data_q;
    logic                  b_full_q;
    logic                  b_fill;
    logic                  b_drain;

    // A takes a new word on every input transfer
    // A flush in the same cycle wins and nothing is stored
    assign a_fill = valid_i && ready_o && !flush_i;

    // A gives up its word whenever B is free to take it or the output
    // is reading A directly, and a flush empties it unconditionally
    assign a_drain = (a_full_q && !b_full_q) || flush_i;

    // B is only loaded when A is moving on but downstream is stalled
    assign b_fill = a_drain && !ready_i && !flush_i;

    // B empties on an output transfer or on a flush
    assign b_drain = (b_full_q && ready_i) || flush_i;

    // Payload slots need no reset, the full flags say when they are valid
    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Occupancy flags, set by a fill and cleared by a drain
    // A fill and a drain in the same cycle leave A full with new data
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    // Input side stalls only with both slots occupied
    // This is registered state, so no path runs from ready_i to ready_o
    assign ready_o = !(a_full_q && b_full_q);

    // Either slot holding a word makes the output valid
    assign valid_o = a_full_q || b_full_q;

    // B always holds the older word, so it is presented first
    assign data_o = b_full_q ? b_data_q : a_data_q;

  end

  // Feeding and flushing in one cycle throws the new word away
  // The upstream side has to keep the two apart
  flush_no_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) flush_i |-> !valid_i
  ) else $warning("spill register flushed while valid_i is high, input word is lost");

endmodule

/* tb.f */
isa_pkg.sv
result_pkg.sv
spill_register_flushable.sv
alu_exec_stage.sv
alu_pipe_top.sv
tb_alu_pipe.sv

/* tb_alu_pipe.sv */
// Operand pipeline testbench
module tb_alu_pipe
  import isa_pkg::*;
  import result_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // Cycle limits for every wait loop
  localparam int unsigned accept_timeout = 50;
  localparam int unsigned drain_timeout  = 200;
  localparam int unsigned random_count   = 300;

  // Expected result and flags packed as the DUT's output register holds them
  typedef logic [res_width+flag_width-1:0] exp_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  cmd_valid_i;
  logic [cmd_width-1:0]  cmd_data_i;
  logic                  cmd_ready_o;
  logic                  res_valid_o;
  logic                  res_ready_i;
  logic [res_width-1:0]  res_data_o;
  logic [flag_width-1:0] res_flags_o;

  // Scoreboard state shared by the stimulus and the compare process
  exp_t        expect_q[$];
  int unsigned err_count;
  int unsigned check_count;
  int unsigned in_count;
  int unsigned out_count;
  bit          toggle_ready;
  bit          saw_stall;

  alu_pipe_top #(
    .in_bypass  (1'b0),
    .out_bypass (1'b0)
  ) i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_data_o  (res_data_o),
    .res_flags_o (res_flags_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  // Expected result and flags of one command word, straight from the ISA rules
  function automatic exp_t expected_result(input logic [cmd_width-1:0] word);
    cmd_u                  c;
    logic [res_width-1:0]  a;
    logic [res_width-1:0]  b;
    logic [wide_width-1:0] v;
    logic [wide_width-1:0] shifted;
    logic [res_width-1:0]  res;
    logic [flag_width-1:0] flags;
    logic                  illegal;
    c       = word;
    a       = res_width'(c.pair.operand_a);
    b       = res_width'(c.pair.operand_b);
    v       = c.wide.value;
    res     = illegal_result;
    illegal = 1'b0;
    case (c.pair.opcode)
      op_add: res = a + b;
      op_sub: res = a - b;
      op_and: res = a & b;
      op_xor: res = a ^ b;
      op_shl: begin
        // Bits pushed past bit 23 are lost
        shifted = v << c.wide.shamt;
        res     = res_width'(shifted);
      end
      op_rol: begin
        // Bits leaving bit 23 come back in at bit 0
        shifted = (v << c.wide.shamt) | (v >> (wide_width - c.wide.shamt));
        res     = res_width'(shifted);
      end
      default: illegal = 1'b1;
    endcase
    flags                   = '0;
    flags[flag_zero_idx]    = (res == '0);
    flags[flag_illegal_idx] = illegal;
    return {res, flags};
  endfunction

  function automatic logic [cmd_width-1:0] make_pair(input logic [opcode_width-1:0] op,
                                                     input logic [pair_op_width-1:0] a,
                                                     input logic [pair_op_width-1:0] b);
    cmd_u c;
    c.pair.opcode    = opcode_e'(op);
    c.pair.operand_a = a;
    c.pair.operand_b = b;
    return c;
  endfunction

  function automatic logic [cmd_width-1:0] make_wide(input logic [opcode_width-1:0] op,
                                                     input logic [wide_width-1:0] value,
                                                     input logic [shamt_width-1:0] shamt);
    cmd_u c;
    c.wide.opcode = opcode_e'(op);
    c.wide.value  = value;
    c.wide.shamt  = shamt;
    return c;
  endfunction

  // Moves to 0.5 ns after the next rising edge, where inputs change
  // Random back-pressure is applied here so it stays on the same time grid
  task automatic next_slot();
    logic [31:0] rnd;
    @(posedge clk_i);
    #0.5;
    if (toggle_ready) begin
      rnd         = $urandom;
      res_ready_i = rnd[0];
    end
  endtask

  // Holds one command on the input until it is taken
  // Ready is read at the falling edge, so the rising edge after it moves the word
  task automatic send_cmd(input logic [cmd_width-1:0] word);
    int unsigned waited;
    bit          accepted;
    waited      = 0;
    accepted    = 1'b0;
    cmd_valid_i = 1'b1;
    cmd_data_i  = word;
    while (!accepted && waited < accept_timeout) begin
      @(negedge clk_i);
      if (cmd_ready_o) begin
        expect_q.push_back(expected_result(word));
        in_count++;
        accepted = 1'b1;
      end else begin
        saw_stall = 1'b1;
      end
      next_slot();
      waited++;
    end
    cmd_valid_i = 1'b0;
    if (!accepted) begin
      $display("command 0x%h was not accepted within %0d cycles", word, accept_timeout);
      err_count++;
    end
  endtask

  // Waits until every expected result has come out, then idles a little
  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (expect_q.size() != 0 && waited < drain_timeout) begin
      next_slot();
      waited++;
    end
    if (expect_q.size() != 0) begin
      $display("%0d results still missing after %0d cycles", expect_q.size(), drain_timeout);
      err_count++;
      expect_q.delete();
    end
    // Idle cycles let any unexpected extra result show up
    repeat (3) next_slot();
  endtask

  task automatic report_test(input string name, input int unsigned errors_at_start);
    if (err_count == errors_at_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - errors_at_start);
    end
  endtask

  // Outputs settle after the rising edge and inputs 0.5 ns later, so the
  // falling edge sees exactly what the next rising edge transfers
  initial begin : compare_outputs
    exp_t exp_word;
    forever begin
      @(negedge clk_i);
      if (rst_ni && res_valid_o && res_ready_i) begin
        out_count++;
        if (expect_q.size() == 0) begin
          $display("a result 0x%h came out with no command outstanding", res_data_o);
          err_count++;
        end else begin
          exp_word = expect_q.pop_front();
          check_count++;
          if (res_data_o !== exp_word[res_width+flag_width-1:flag_width]) begin
            $display("error: res_data_o = 0x%h, expected 0x%h", res_data_o,
                     exp_word[res_width+flag_width-1:flag_width]);
            err_count++;
          end
          if (res_flags_o !== exp_word[flag_width-1:0]) begin
            $display("error: res_flags_o = 0x%h, expected 0x%h", res_flags_o,
                     exp_word[flag_width-1:0]);
            err_count++;
          end
        end
      end
    end
  end

  initial begin : run_tests
    int unsigned      errs;
    int unsigned      in0;
    int unsigned      out0;
    int unsigned      pick;
    int unsigned      edges;
    int unsigned      waited;
    bit               seen;
    logic [3:0]       code;
    logic [31:0]      rnd;
    logic [cmd_width-1:0] word;

    void'($urandom(32'h2e93));
    err_count    = 0;
    check_count  = 0;
    in_count     = 0;
    out_count    = 0;
    toggle_ready = 1'b0;
    saw_stall    = 1'b0;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_data_i   = '0;
    res_ready_i  = 1'b1;
    repeat (2) next_slot();
    rst_ni = 1'b1;

    // Pair form, including carry past bit 13, a borrow below zero and zero results
    errs = err_count;
    send_cmd(make_pair(op_add, 14'h3fff, 14'h3fff));
    send_cmd(make_pair(op_add, 14'h0000, 14'h0000));
    send_cmd(make_pair(op_sub, 14'h0005, 14'h0009));
    send_cmd(make_pair(op_sub, 14'h2000, 14'h2000));
    send_cmd(make_pair(op_and, 14'h3c3c, 14'h0ff0));
    send_cmd(make_pair(op_and, 14'h2aaa, 14'h1555));
    send_cmd(make_pair(op_xor, 14'h1555, 14'h1555));
    send_cmd(make_pair(op_xor, 14'h3f00, 14'h00ff));
    wait_drain();
    report_test("1 pair ops", errs);

    // Wide form with shift amounts 0, 1 and 15
    errs = err_count;
    send_cmd(make_wide(op_shl, 24'habcdef, 4'd0));
    send_cmd(make_wide(op_shl, 24'h800000, 4'd1));
    send_cmd(make_wide(op_shl, 24'h00c3a5, 4'd15));
    send_cmd(make_wide(op_rol, 24'habcdef, 4'd0));
    send_cmd(make_wide(op_rol, 24'h800000, 4'd1));
    send_cmd(make_wide(op_rol, 24'hc00001, 4'd15));
    wait_drain();
    report_test("2 wide ops", errs);

    // Every unused opcode must come back as zero with both flags set
    errs = err_count;
    for (int i = 0; i < 16; i++) begin
      code = i[3:0];
      if (!(code inside {op_add, op_sub, op_and, op_xor, op_shl, op_rol})) begin
        send_cmd(make_pair(code, 14'h1234, 14'h0f0f));
      end
    end
    wait_drain();
    report_test("3 illegal ops", errs);

    // Reset a pipeline that holds four commands under back-pressure,
    // then latency of a single command with no back-pressure
    errs        = err_count;
    res_ready_i = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_cmd(make_pair(op_xor, 14'(i), 14'h0101));
    end
    rst_ni = 1'b0;
    // Reset throws the held commands away
    expect_q.delete();
    repeat (2) next_slot();
    rst_ni      = 1'b1;
    res_ready_i = 1'b1;
    if (cmd_ready_o !== 1'b1) begin
      $display("error: cmd_ready_o = 0x%h after reset, expected 0x1", cmd_ready_o);
      err_count++;
    end
    if (res_valid_o !== 1'b0) begin
      $display("error: res_valid_o = 0x%h after reset, expected 0x0", res_valid_o);
      err_count++;
    end
    send_cmd(make_pair(op_add, 14'h0011, 14'h0022));
    // The accepting edge counts as the first one
    edges  = 1;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < accept_timeout) begin
      @(negedge clk_i);
      if (res_valid_o) begin
        seen = 1'b1;
      end else begin
        next_slot();
        edges++;
      end
      waited++;
    end
    if (!seen) begin
      $display("res_valid_o never rose after the single command was accepted");
      err_count++;
    end else if (edges != 2) begin
      $display("error: res_valid_o latency = 0x%0h edges, expected 0x2", edges);
      err_count++;
    end
    wait_drain();
    report_test("4 reset and latency", errs);

    // Random traffic against random back-pressure
    errs      = err_count;
    in0       = in_count;
    out0      = out_count;
    saw_stall = 1'b0;
    toggle_ready = 1'b1;
    for (int n = 0; n < random_count; n++) begin
      rnd = $urandom;
      // Idle gap before roughly one command in four
      if (rnd[1:0] == 2'b00) begin
        next_slot();
      end
      word = $urandom;
      pick = $urandom_range(6, 0);
      case (pick)
        0: word[31:28] = op_add;
        1: word[31:28] = op_sub;
        2: word[31:28] = op_and;
        3: word[31:28] = op_xor;
        4: word[31:28] = op_shl;
        5: word[31:28] = op_rol;
        default: word[31:28] = rnd[7:4];
      endcase
      send_cmd(word);
    end
    toggle_ready = 1'b0;
    res_ready_i  = 1'b1;
    wait_drain();
    if ((out_count - out0) != (in_count - in0)) begin
      $display("error: output count = 0x%0h, expected 0x%0h", out_count - out0, in_count - in0);
      err_count++;
    end
    if (!saw_stall) begin
      $display("cmd_ready_o was never seen low during the random run");
      err_count++;
    end
    report_test("5 random traffic", errs);

    // Fill all four slots under back-pressure, then flush them away
    errs        = err_count;
    res_ready_i = 1'b0;
    send_cmd(make_pair(op_add, 14'h0001, 14'h0001));
    send_cmd(make_pair(op_sub, 14'h0002, 14'h0001));
    send_cmd(make_wide(op_shl, 24'h000001, 4'd3));
    send_cmd(make_pair(op_xor, 14'h00f0, 14'h000f));
    if (cmd_ready_o !== 1'b0) begin
      $display("error: cmd_ready_o = 0x%h with four commands held, expected 0x0", cmd_ready_o);
      err_count++;
    end
    flush_i = 1'b1;
    next_slot();
    flush_i = 1'b0;
    // The four held commands are gone and must never reach the output
    expect_q.delete();
    if (res_valid_o !== 1'b0) begin
      $display("error: res_valid_o = 0x%h after flush, expected 0x0", res_valid_o);
      err_count++;
    end
    if (cmd_ready_o !== 1'b1) begin
      $display("error: cmd_ready_o = 0x%h after flush, expected 0x1", cmd_ready_o);
      err_count++;
    end
    out0        = out_count;
    res_ready_i = 1'b1;
    send_cmd(make_pair(op_and, 14'h3fff, 14'h0abc));
    send_cmd(make_wide(op_rol, 24'h123456, 4'd4));
    send_cmd(make_pair(op_sub, 14'h0000, 14'h0001));
    wait_drain();
    if ((out_count - out0) != 3) begin
      $display("error: outputs after flush = 0x%0h, expected 0x3", out_count - out0);
      err_count++;
    end
    report_test("6 flush", errs);

    $display("tests 6, results checked %0d, commands accepted %0d, errors %0d",
             check_count, in_count, err_count);
    if (err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
